// ==== source/openadc_defines.svh ====
`ifndef OPENADC_DEFINES_SVH
`define OPENADC_DEFINES_SVH

// datapath widths
`define OADC_SAMPLE_W            12
`define OADC_COUNT_W             24

// register map with one byte per address
`define OADC_ADDR_SETTINGS       8'h01
`define OADC_ADDR_STATUS         8'h02
`define OADC_ADDR_GAIN           8'h04
`define OADC_ADDR_TRIG_LEVEL_LO  8'h05
`define OADC_ADDR_TRIG_LEVEL_HI  8'h06
`define OADC_ADDR_LIMIT_0        8'h10
`define OADC_ADDR_LIMIT_1        8'h11
`define OADC_ADDR_LIMIT_2        8'h12
`define OADC_ADDR_EXTCLK_FREQ_0  8'h20
`define OADC_ADDR_EXTCLK_FREQ_1  8'h21
`define OADC_ADDR_EXTCLK_FREQ_2  8'h22

// settings byte bits with led select in LED_LO and the bit above
`define OADC_SET_SOURCE          0
`define OADC_SET_ARM             3
`define OADC_SET_LED_LO          4
`define OADC_SET_MON_DIS         6

// status byte
`define OADC_STAT_ARMED          0
`define OADC_STAT_PLL            4
`define OADC_STAT_EXTCLK_CHANGE  5

`endif

// ==== source/openadc_pkg.sv ====
`include "openadc_defines.svh"

package openadc_pkg;

   // configuration fanned out from the register block
   typedef struct packed {
      logic                      source_adc;       // 1 = adc pins, 0 = test counter
      logic [1:0]                led_select;
      logic                      monitor_disabled; // also clears the change flag
      logic [`OADC_SAMPLE_W-1:0] trigger_level;    // msb picks the compare direction
      logic [`OADC_COUNT_W-1:0]  extclk_limit;
   } adc_cfg_t;

   // status returned to the register block
   typedef struct packed {
      logic                      armed;
      logic                      extclk_change;    // sticky
      logic [`OADC_COUNT_W-1:0]  extclk_count;     // last finished window
   } core_status_t;

endpackage

// ==== source/adc_reg_block.sv ====
`timescale 1ns/1ps
`include "openadc_defines.svh"

module adc_reg_block (
   input  logic                      clk_usb,
   input  logic                      reset,
   input  logic [7:0]                reg_address_i,
   input  logic [7:0]                reg_datai_i,
   input  logic                      reg_write_i,
   input  logic                      reg_read_i,
   input  logic                      pll_status_i,
   input  openadc_pkg::core_status_t status_i,
   output logic [7:0]                reg_datao_o,
   output openadc_pkg::adc_cfg_t     cfg_o,
   output logic                      arm_o,
   output logic                      amp_gain_o
);

   localparam logic [7:0] ARM_MASK = 8'h01 << `OADC_SET_ARM;

   logic [7:0]               settings_q;
   logic [7:0]               gain_q;
   logic [7:0]               level_lo_q;
   logic [7:0]               level_hi_q;   // only the low nibble reaches the trigger
   logic [`OADC_COUNT_W-1:0] limit_q;
   logic [8:0]               pwm_acc;
   logic [7:0]               status_byte;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         settings_q <= 8'h00;
         gain_q     <= 8'h00;
         level_lo_q <= 8'h00;
         level_hi_q <= 8'h00;
         limit_q    <= '0;
         arm_o      <= 1'b0;
      end else begin
         arm_o <= reg_write_i && (reg_address_i == `OADC_ADDR_SETTINGS) &&
                  reg_datai_i[`OADC_SET_ARM];
         if (reg_write_i) begin
            case (reg_address_i)
               `OADC_ADDR_SETTINGS:      settings_q <= reg_datai_i & ~ARM_MASK; // arm is a command
               `OADC_ADDR_GAIN:          gain_q <= reg_datai_i;
               `OADC_ADDR_TRIG_LEVEL_LO: level_lo_q <= reg_datai_i;
               `OADC_ADDR_TRIG_LEVEL_HI: level_hi_q <= reg_datai_i;
               `OADC_ADDR_LIMIT_0:       limit_q[7:0] <= reg_datai_i;
               `OADC_ADDR_LIMIT_1:       limit_q[15:8] <= reg_datai_i;
               `OADC_ADDR_LIMIT_2:       limit_q[23:16] <= reg_datai_i;
               default: ;
            endcase
         end
      end
   end

   // carry out of the low byte drives the gain pwm
   always_ff @(posedge clk_usb) begin
      if (reset)
         pwm_acc <= 9'h000;
      else
         pwm_acc <= {1'b0, pwm_acc[7:0]} + {1'b0, gain_q};
   end

   assign amp_gain_o = pwm_acc[8];

   always_comb begin
      cfg_o.source_adc       = settings_q[`OADC_SET_SOURCE];
      cfg_o.led_select       = settings_q[`OADC_SET_LED_LO +: 2];
      cfg_o.monitor_disabled = settings_q[`OADC_SET_MON_DIS];
      cfg_o.trigger_level    = {level_hi_q[3:0], level_lo_q};
      cfg_o.extclk_limit     = limit_q;
   end

   always_comb begin
      status_byte = 8'h00;
      status_byte[`OADC_STAT_ARMED]         = status_i.armed;
      status_byte[`OADC_STAT_PLL]           = pll_status_i;
      status_byte[`OADC_STAT_EXTCLK_CHANGE] = status_i.extclk_change;
   end

   // readback is zero unless a read is in progress
   always_comb begin
      reg_datao_o = 8'h00;
      if (reg_read_i) begin
         case (reg_address_i)
            `OADC_ADDR_SETTINGS:      reg_datao_o = settings_q;
            `OADC_ADDR_STATUS:        reg_datao_o = status_byte;
            `OADC_ADDR_GAIN:          reg_datao_o = gain_q;
            `OADC_ADDR_TRIG_LEVEL_LO: reg_datao_o = level_lo_q;
            `OADC_ADDR_TRIG_LEVEL_HI: reg_datao_o = level_hi_q;
            `OADC_ADDR_LIMIT_0:       reg_datao_o = limit_q[7:0];
            `OADC_ADDR_LIMIT_1:       reg_datao_o = limit_q[15:8];
            `OADC_ADDR_LIMIT_2:       reg_datao_o = limit_q[23:16];
            `OADC_ADDR_EXTCLK_FREQ_0: reg_datao_o = status_i.extclk_count[7:0];
            `OADC_ADDR_EXTCLK_FREQ_1: reg_datao_o = status_i.extclk_count[15:8];
            `OADC_ADDR_EXTCLK_FREQ_2: reg_datao_o = status_i.extclk_count[23:16];
            default:                  reg_datao_o = 8'h00;
         endcase
      end
   end

endmodule

// ==== source/adc_sample_path.sv ====
`timescale 1ns/1ps
`include "openadc_defines.svh"

module adc_sample_path (
   input  logic                      clk_usb,
   input  logic                      reset,
   input  logic [`OADC_SAMPLE_W-1:0] adc_data_i,
   input  openadc_pkg::adc_cfg_t     cfg_i,
   output logic [`OADC_SAMPLE_W-1:0] sample_o
);

   logic [`OADC_SAMPLE_W-1:0] test_cnt;   // ramp for bring-up without an adc
   logic [`OADC_SAMPLE_W-1:0] stage0;
   logic [`OADC_SAMPLE_W-1:0] stage1;

   always_ff @(posedge clk_usb) begin
      if (reset)
         test_cnt <= '0;
      else
         test_cnt <= test_cnt + {{(`OADC_SAMPLE_W-1){1'b0}}, 1'b1};
   end

   // two resample stages
   always_ff @(posedge clk_usb) begin
      stage0 <= cfg_i.source_adc ? adc_data_i : test_cnt;
      stage1 <= stage0;
   end

   assign sample_o = stage1;

endmodule

// ==== source/adc_level_trigger.sv ====
`timescale 1ns/1ps
`include "openadc_defines.svh"

module adc_level_trigger (
   input  logic                      clk_usb,
   input  logic                      reset,
   input  logic [`OADC_SAMPLE_W-1:0] sample_i,
   input  logic                      arm_i,
   input  openadc_pkg::adc_cfg_t     cfg_i,
   output logic                      armed_o,
   output logic                      trigger_adc_o
);

   logic armed_q;
   logic trigger_q;
   logic level_hit;

   // msb of the level selects above or below
   always_comb begin
      if (cfg_i.trigger_level[`OADC_SAMPLE_W-1])
         level_hit = sample_i > cfg_i.trigger_level;
      else
         level_hit = sample_i < cfg_i.trigger_level;
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         armed_q   <= 1'b0;
         trigger_q <= 1'b0;
      end else begin
         trigger_q <= armed_q && level_hit;
         if (armed_q && level_hit)
            armed_q <= 1'b0;      // single shot
         else if (arm_i)
            armed_q <= 1'b1;      // re-arm while armed changes nothing
      end
   end

   assign armed_o       = armed_q;
   assign trigger_adc_o = trigger_q;

endmodule

// ==== source/status_led_driver.sv ====
`timescale 1ns/1ps

module status_led_driver #(
   parameter int WINDOW_LOG2 = 23
) (
   input  logic                  clk_usb,
   input  logic                  reset,
   input  logic                  armed_i,
   input  logic                  extclk_change_i,
   input  openadc_pkg::adc_cfg_t cfg_i,
   output logic                  meas_strobe_o,
   output logic                  led_armed_o,
   output logic                  led_capture_o
);

   localparam int HB_W = WINDOW_LOG2 + 3;   // three spare bits for the led rates

   logic [HB_W-1:0] heartbeat;
   logic            strobe_q;
   logic            flash_q;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         heartbeat <= '0;
         strobe_q  <= 1'b0;
         flash_q   <= 1'b0;
      end else begin
         heartbeat <= heartbeat + HB_W'(1);
         strobe_q  <= &heartbeat[WINDOW_LOG2-1:0];   // window wrap
         flash_q   <= heartbeat[HB_W-1] & ~heartbeat[HB_W-3];  // short double blink
      end
   end

   assign meas_strobe_o = strobe_q;

   always_comb begin
      if (extclk_change_i) begin
         led_armed_o   = flash_q;
         led_capture_o = flash_q;
      end else begin
         case (cfg_i.led_select)
            2'd1: begin
               led_armed_o   = heartbeat[HB_W-1];
               led_capture_o = heartbeat[HB_W-2];
            end
            2'd2: begin
               led_armed_o   = heartbeat[HB_W-2];
               led_capture_o = heartbeat[HB_W-3];
            end
            2'd3: begin
               led_armed_o   = heartbeat[HB_W-1];
               led_capture_o = ~heartbeat[HB_W-1];
            end
            default: begin
               led_armed_o   = armed_i;
               led_capture_o = armed_i;   // trigger allowed is armed here
            end
         endcase
      end
   end

endmodule

// ==== source/extclk_monitor.sv ====
`timescale 1ns/1ps
`include "openadc_defines.svh"

module extclk_monitor (
   input  logic                     clk_usb,
   input  logic                     reset,
   input  logic                     ext_clk_i,
   input  logic                     meas_strobe_i,
   input  openadc_pkg::adc_cfg_t    cfg_i,
   output logic [`OADC_COUNT_W-1:0] extclk_count_o,
   output logic                     extclk_change_o
);

   logic                     sync_q1;
   logic                     sync_q2;
   logic                     prev_q;
   logic                     rise;
   logic [`OADC_COUNT_W-1:0] count_q;
   logic [`OADC_COUNT_W-1:0] window_count;
   logic [`OADC_COUNT_W-1:0] last_q;
   logic [`OADC_COUNT_W-1:0] delta;
   logic                     change_q;

   // target clock is only sampled as data
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         sync_q1 <= 1'b0;
         sync_q2 <= 1'b0;
         prev_q  <= 1'b0;
      end else begin
         sync_q1 <= ext_clk_i;
         sync_q2 <= sync_q1;
         prev_q  <= sync_q2;
      end
   end

   assign rise = sync_q2 & ~prev_q;

   // count including an edge that lands on the strobe cycle
   assign window_count = count_q + {{(`OADC_COUNT_W-1){1'b0}}, rise};
   assign delta = (window_count > last_q) ? window_count - last_q : last_q - window_count;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         count_q  <= '0;
         last_q   <= '0;
         change_q <= 1'b0;
      end else begin
         if (meas_strobe_i) begin
            count_q <= '0;
            last_q  <= window_count;
         end else begin
            count_q <= window_count;
         end

         if (cfg_i.monitor_disabled)
            change_q <= 1'b0;
         else if (meas_strobe_i && (last_q != '0) && (delta > cfg_i.extclk_limit))
            change_q <= 1'b1;   // sticky until disabled
      end
   end

   assign extclk_count_o  = last_q;
   assign extclk_change_o = change_q;

endmodule

// ==== source/openadc_core.sv ====
`timescale 1ns/1ps
`include "openadc_defines.svh"

module openadc_core #(
   parameter int WINDOW_LOG2 = 23
) (
   input  logic                      clk_usb,
   input  logic                      reset,
   input  logic [`OADC_SAMPLE_W-1:0] adc_data_i,
   input  logic                      ext_clk_i,
   input  logic                      pll_status_i,
   input  logic [7:0]                reg_address_i,
   input  logic [7:0]                reg_datai_i,
   input  logic                      reg_write_i,
   input  logic                      reg_read_i,
   output logic [7:0]                reg_datao_o,
   output logic                      trigger_adc_o,
   output logic                      freq_measure_o,
   output logic                      amp_gain_o,
   output logic                      led_armed_o,
   output logic                      led_capture_o
);

   openadc_pkg::adc_cfg_t     cfg;
   openadc_pkg::core_status_t status;
   logic                      arm;
   logic                      armed;
   logic                      extclk_change;
   logic [`OADC_COUNT_W-1:0]  extclk_count;
   logic [`OADC_SAMPLE_W-1:0] sample;
   logic                      meas_strobe;

   always_comb begin
      status.armed         = armed;
      status.extclk_change = extclk_change;
      status.extclk_count  = extclk_count;
   end

   assign freq_measure_o = meas_strobe;

   adc_reg_block u_reg_block (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .reg_address_i  (reg_address_i),
      .reg_datai_i    (reg_datai_i),
      .reg_write_i    (reg_write_i),
      .reg_read_i     (reg_read_i),
      .pll_status_i   (pll_status_i),
      .status_i       (status),
      .reg_datao_o    (reg_datao_o),
      .cfg_o          (cfg),
      .arm_o          (arm),
      .amp_gain_o     (amp_gain_o)
   );

   adc_sample_path u_sample_path (
      .clk_usb    (clk_usb),
      .reset      (reset),
      .adc_data_i (adc_data_i),
      .cfg_i      (cfg),
      .sample_o   (sample)
   );

   adc_level_trigger u_level_trigger (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .sample_i      (sample),
      .arm_i         (arm),
      .cfg_i         (cfg),
      .armed_o       (armed),
      .trigger_adc_o (trigger_adc_o)
   );

   status_led_driver #(
      .WINDOW_LOG2 (WINDOW_LOG2)
   ) u_led_driver (
      .clk_usb         (clk_usb),
      .reset           (reset),
      .armed_i         (armed),
      .extclk_change_i (extclk_change),
      .cfg_i           (cfg),
      .meas_strobe_o   (meas_strobe),
      .led_armed_o     (led_armed_o),
      .led_capture_o   (led_capture_o)
   );

   extclk_monitor u_extclk_monitor (
      .clk_usb         (clk_usb),
      .reset           (reset),
      .ext_clk_i       (ext_clk_i),
      .meas_strobe_i   (meas_strobe),
      .cfg_i           (cfg),
      .extclk_count_o  (extclk_count),
      .extclk_change_o (extclk_change)
   );

endmodule

// ==== tb/openadc_core_tb.sv ====
`timescale 1ns/1ps
`include "openadc_defines.svh"

module openadc_core_tb;

   localparam int WINDOW_LOG2     = 8;
   localparam int WINDOW          = 1 << WINDOW_LOG2;
   localparam int WATCHDOG_CYCLES = 20 * WINDOW + 5000;
   localparam logic [7:0] SET_SOURCE  = 8'h01 << `OADC_SET_SOURCE;
   localparam logic [7:0] SET_ARM     = 8'h01 << `OADC_SET_ARM;
   localparam logic [7:0] SET_MON_DIS = 8'h01 << `OADC_SET_MON_DIS;

   logic                      clk_usb = 1'b0;
   logic                      reset;
   logic [`OADC_SAMPLE_W-1:0] adc_data_i;
   logic                      ext_clk_i = 1'b0;   // only the generator below drives it
   logic                      pll_status_i;
   logic [7:0]                reg_address_i;
   logic [7:0]                reg_datai_i;
   logic                      reg_write_i;
   logic                      reg_read_i;
   logic [7:0]                reg_datao_o;
   logic                      trigger_adc_o;
   logic                      freq_measure_o;
   logic                      amp_gain_o;
   logic                      led_armed_o;
   logic                      led_capture_o;

   integer seed        = 32'hb010_e06d;
   int     half_period = 0;   // target clock half period in clk_usb cycles and 0 when stopped
   int     toggle_cnt  = 0;

   openadc_core #(
      .WINDOW_LOG2 (WINDOW_LOG2)
   ) openadc_core_inst (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .adc_data_i     (adc_data_i),
      .ext_clk_i      (ext_clk_i),
      .pll_status_i   (pll_status_i),
      .reg_address_i  (reg_address_i),
      .reg_datai_i    (reg_datai_i),
      .reg_write_i    (reg_write_i),
      .reg_read_i     (reg_read_i),
      .reg_datao_o    (reg_datao_o),
      .trigger_adc_o  (trigger_adc_o),
      .freq_measure_o (freq_measure_o),
      .amp_gain_o     (amp_gain_o),
      .led_armed_o    (led_armed_o),
      .led_capture_o  (led_capture_o)
   );

   always #5 clk_usb = ~clk_usb;

   // slow target clock toggling every half_period cycles
   always @(posedge clk_usb) begin
      if (half_period != 0) begin
         if (toggle_cnt >= half_period - 1) begin
            toggle_cnt <= 0;
            ext_clk_i  <= ~ext_clk_i;
         end else begin
            toggle_cnt <= toggle_cnt + 1;
         end
      end
   end

   initial begin
      #(WATCHDOG_CYCLES * 10);
      $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
      end_with_failure();
   end

   function automatic logic [31:0] rand_word();
      rand_word = $random(seed);
   endfunction

   // reference models
   function automatic logic [7:0] expected_status(input logic pll, input logic armed,
                                                   input logic change);
      logic [7:0] s;
      s = 8'h00;
      s[`OADC_STAT_ARMED]         = armed;
      s[`OADC_STAT_PLL]           = pll;
      s[`OADC_STAT_EXTCLK_CHANGE] = change;
      return s;
   endfunction

   function automatic logic level_qualifies(input logic [11:0] value, input logic [11:0] level);
      if (level[11])
         return value > level;   // rising through a high level
      return value < level;
   endfunction

   function automatic int edges_per_window(input int k);
      return WINDOW / (2 * k);   // one rising edge per 2k cycles
   endfunction

   task automatic end_with_failure();
      $display("test failed");
      $fatal(1);
   endtask

   task automatic check_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
         end_with_failure();
      end
   endtask

   task automatic check_near(input string name, input int got, input int exp, input int tol);
      assert ((got >= exp - tol) && (got <= exp + tol)) else begin
         $display("[ERROR] %s got 0x%0h expected 0x%0h +/- %0d", name, got, exp, tol);
         end_with_failure();
      end
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
      @(posedge clk_usb);
      reg_address_i <= addr;
      reg_datai_i   <= data;
      reg_write_i   <= 1'b1;
      @(posedge clk_usb);   // write lands on this edge
      reg_write_i   <= 1'b0;
   endtask

   task automatic read_reg(input logic [7:0] addr, output logic [7:0] data);
      @(posedge clk_usb);
      reg_address_i <= addr;
      reg_read_i    <= 1'b1;
      @(negedge clk_usb);
      data = reg_datao_o;
      @(posedge clk_usb);
      reg_read_i    <= 1'b0;
   endtask

   task automatic read_check(input logic [7:0] addr, input logic [7:0] exp);
      logic [7:0] data;
      read_reg(addr, data);
      check_equal($sformatf("reg_datao_o at address %02h", addr), 32'(data), 32'(exp));
   endtask

   task automatic write_read_random(input logic [7:0] addr);
      logic [31:0] rnd;
      rnd = rand_word();
      write_reg(addr, rnd[7:0]);
      read_check(addr, rnd[7:0]);
   endtask

   // cycles until the next measurement strobe
   task automatic strobe_gap(output int gap);
      gap = 0;
      do begin
         @(negedge clk_usb);
         gap++;
         if (gap > 2 * WINDOW) begin
            $display("no measurement strobe seen within two windows");
            end_with_failure();
         end
      end while (freq_measure_o !== 1'b1);
   endtask

   task automatic watch_trigger(output int pulses, output logic saw_armed);
      pulses    = 0;
      saw_armed = 1'b0;
      repeat (12) begin
         @(negedge clk_usb);
         if (led_armed_o)
            saw_armed = 1'b1;
         if (trigger_adc_o)
            pulses++;   // counts high cycles so a wide pulse shows up more than once
      end
   endtask

   initial begin
      logic [31:0] rnd;
      logic [11:0] level;
      logic [11:0] value;
      logic [7:0]  b0;
      logic [7:0]  b1;
      logic [7:0]  b2;
      logic        hit;
      logic        saw_armed;
      logic        saw_high;
      logic        saw_low;
      logic        pll;
      int          pulses;
      int          gap;
      int          k;
      int          highs;

      reset         <= 1'b1;
      adc_data_i    <= '0;
      pll_status_i  <= 1'b0;
      reg_address_i <= 8'h00;
      reg_datai_i   <= 8'h00;
      reg_write_i   <= 1'b0;
      reg_read_i    <= 1'b0;
      repeat (10) @(posedge clk_usb);
      reset <= 1'b0;

      // state after reset
      @(negedge clk_usb);
      check_equal("trigger_adc_o", 32'(trigger_adc_o), 32'd0);
      check_equal("freq_measure_o", 32'(freq_measure_o), 32'd0);
      check_equal("amp_gain_o", 32'(amp_gain_o), 32'd0);
      read_check(`OADC_ADDR_SETTINGS, 8'h00);
      read_check(`OADC_ADDR_GAIN, 8'h00);
      read_check(`OADC_ADDR_TRIG_LEVEL_LO, 8'h00);
      read_check(`OADC_ADDR_TRIG_LEVEL_HI, 8'h00);
      read_check(`OADC_ADDR_LIMIT_0, 8'h00);
      read_check(`OADC_ADDR_LIMIT_1, 8'h00);
      read_check(`OADC_ADDR_LIMIT_2, 8'h00);

      // register write and readback
      write_read_random(`OADC_ADDR_GAIN);
      write_read_random(`OADC_ADDR_TRIG_LEVEL_LO);
      write_read_random(`OADC_ADDR_TRIG_LEVEL_HI);
      write_read_random(`OADC_ADDR_LIMIT_0);
      write_read_random(`OADC_ADDR_LIMIT_1);
      write_read_random(`OADC_ADDR_LIMIT_2);
      pll = 1'b0;
      repeat (2) begin
         pll = ~pll;
         pll_status_i <= pll;
         read_check(`OADC_ADDR_STATUS, expected_status(pll, 1'b0, 1'b0));
      end

      // gain pwm duty is gain out of every 256 cycles
      rnd = rand_word();
      write_reg(`OADC_ADDR_GAIN, rnd[7:0]);
      repeat (4) @(negedge clk_usb);
      highs = 0;
      repeat (256) begin
         @(negedge clk_usb);
         if (amp_gain_o)
            highs++;
      end
      check_equal("amp_gain_o high cycles per 256", 32'(highs), 32'(rnd[7:0]));

      // level trigger in both compare directions with the adc pins as source
      write_reg(`OADC_ADDR_SETTINGS, SET_SOURCE);
      for (int mode = 0; mode < 2; mode++) begin
         rnd   = rand_word();
         level = {(mode == 1), rnd[10:0]};
         if (level == 12'hfff)
            level = 12'hffe;
         if (level == 12'h000)
            level = 12'h001;   // keep a value that can qualify
         write_reg(`OADC_ADDR_TRIG_LEVEL_LO, level[7:0]);
         write_reg(`OADC_ADDR_TRIG_LEVEL_HI, {4'h0, level[11:8]});
         rnd   = rand_word();
         value = rnd[11:0];
         adc_data_i <= value;
         repeat (4) @(posedge clk_usb);
         hit = level_qualifies(value, level);
         write_reg(`OADC_ADDR_SETTINGS, SET_SOURCE | SET_ARM);
         watch_trigger(pulses, saw_armed);
         check_equal("led_armed_o seen high after arm", 32'(saw_armed), 32'd1);
         check_equal("trigger_adc_o high cycles", 32'(pulses), hit ? 32'd1 : 32'd0);
         check_equal("led_armed_o", 32'(led_armed_o), 32'(!hit));
         if (!hit) begin
            @(posedge clk_usb);
            adc_data_i <= level[11] ? 12'hfff : 12'h000;   // still armed so full scale fires it
            watch_trigger(pulses, saw_armed);
            check_equal("trigger_adc_o high cycles", 32'(pulses), 32'd1);
            check_equal("led_armed_o", 32'(led_armed_o), 32'd0);
         end
      end

      // measurement strobe and edge count with the change flag held clear
      write_reg(`OADC_ADDR_SETTINGS, SET_MON_DIS);
      write_reg(`OADC_ADDR_LIMIT_0, 8'h02);
      write_reg(`OADC_ADDR_LIMIT_1, 8'h00);
      write_reg(`OADC_ADDR_LIMIT_2, 8'h00);
      rnd = rand_word();
      k   = 3 + int'(rnd[2:0]);
      half_period <= k;
      strobe_gap(gap);
      repeat (2) begin
         strobe_gap(gap);
         check_equal("freq_measure_o period", 32'(gap), 32'(WINDOW));
      end
      read_reg(`OADC_ADDR_EXTCLK_FREQ_0, b0);
      read_reg(`OADC_ADDR_EXTCLK_FREQ_1, b1);
      read_reg(`OADC_ADDR_EXTCLK_FREQ_2, b2);
      check_near("extclk_count", int'({8'h00, b2, b1, b0}), edges_per_window(k), 1);

      // steady windows with the monitor enabled leave the flag clear
      write_reg(`OADC_ADDR_SETTINGS, 8'h00);
      repeat (2) strobe_gap(gap);
      read_check(`OADC_ADDR_STATUS, expected_status(pll, 1'b0, 1'b0));

      // halving the target clock moves the count well past the limit of 2
      @(posedge clk_usb);
      half_period <= 2 * k;
      repeat (3) strobe_gap(gap);
      read_check(`OADC_ADDR_STATUS, expected_status(pll, 1'b0, 1'b1));
      saw_high = 1'b0;
      saw_low  = 1'b0;
      repeat (8 * WINDOW) begin   // one full flash period
         @(negedge clk_usb);
         check_equal("led_capture_o", 32'(led_capture_o), 32'(led_armed_o));
         if (led_armed_o)
            saw_high = 1'b1;
         else
            saw_low = 1'b1;
      end
      check_equal("led flash high seen", 32'(saw_high), 32'd1);
      check_equal("led flash low seen", 32'(saw_low), 32'd1);
      write_reg(`OADC_ADDR_SETTINGS, SET_MON_DIS);
      read_check(`OADC_ADDR_STATUS, expected_status(pll, 1'b0, 1'b0));

      $display("test passed");
      $finish;
   end

endmodule

// ==== flist.f ====
+incdir+source
source/openadc_pkg.sv
source/adc_reg_block.sv
source/adc_sample_path.sv
source/adc_level_trigger.sv
source/status_led_driver.sv
source/extclk_monitor.sv
source/openadc_core.sv
tb/openadc_core_tb.sv

// ==== Makefile ====
# Verilator build and run of the openadc core testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --top-module openadc_core_tb -f flist.f
	@out="$$(./obj_dir/Vopenadc_core_tb)"; echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
